// ==== logic/float_cfg.svh ====
// float format widths
`ifndef FLOAT_CFG_SVH
`define FLOAT_CFG_SVH

// whole word
`define FLOAT_BITS 32

// biased exponent field
`define FLOAT_EXP_BITS 8

// stored mantissa without the hidden bit
`define FLOAT_MANT_BITS 23

// exponent offset of the format
`define FLOAT_EXP_BIAS 127

`endif

// ==== logic/float_pkg.sv ====
// float unit types
`include "float_cfg.svh"

package float_pkg;

	// packed sign, exponent and stored mantissa
	typedef logic [`FLOAT_BITS-1:0] float_t;

	// biased exponent
	typedef logic [`FLOAT_EXP_BITS-1:0] exp_t;

	// mantissa with hidden bit
	typedef logic [`FLOAT_MANT_BITS:0] mant_t;

	// working mantissa
	// wide enough to hold the divide step's double shift
	typedef logic [2*`FLOAT_MANT_BITS:0] wide_mant_t;

	// operation code
	typedef logic [1:0] op_t;

	localparam op_t OP_MUL = 2'b00;
	localparam op_t OP_DIV = 2'b01;
	localparam op_t OP_ADD = 2'b10;
	localparam op_t OP_SUB = 2'b11;

	// normaliser states
	typedef enum logic [1:0] {
		IDLE,
		SHIFT_DOWN,  // mantissa reaches past the hidden bit
		SHIFT_UP     // hidden bit still clear
	} norm_state_t;

endpackage

// ==== logic/float_arith.sv ====
// float arithmetic step
`include "float_cfg.svh"

module float_arith (
	input  logic                  in_clk,
	input  logic                  in_rst,
	input  logic                  start,
	input  float_pkg::float_t     a,
	input  float_pkg::float_t     b,
	input  float_pkg::op_t        op,
	input  logic                  norm_done,
	output logic                  ready,
	output logic                  raw_valid,
	output logic                  raw_sign,
	output float_pkg::exp_t       raw_exp,
	output float_pkg::wide_mant_t raw_mant
);
	import float_pkg::*;

	localparam exp_t BIAS = exp_t'(`FLOAT_EXP_BIAS);
	localparam exp_t MANT_SHIFT = exp_t'(`FLOAT_MANT_BITS);

	logic busy;    // operation in flight until norm_done
	logic calc;    // operands captured, step runs this cycle
	logic accept;

	// captured operands
	float_t a_q;
	float_t b_q;
	op_t    op_q;

	// operand fields
	logic  a_sign;
	logic  b_sign;
	logic  b_eff_sign;
	exp_t  a_exp;
	exp_t  b_exp;
	mant_t a_mant;
	mant_t b_mant;

	// add and subtract alignment
	logic  a_big;
	logic  big_sign;
	logic  small_sign;
	exp_t  big_exp;
	exp_t  exp_diff;
	mant_t big_mant;
	mant_t small_mant;
	mant_t small_al;

	// multiply and divide
	logic [2*`FLOAT_MANT_BITS+1:0] prod;
	wide_mant_t                    quot;

	// step results before the register
	logic       sign_d;
	exp_t       exp_d;
	wide_mant_t mant_d;

	assign accept = start && !busy;
	assign ready = !busy;

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			busy <= 1'b0;
			calc <= 1'b0;
			raw_valid <= 1'b0;
		end else begin
			calc <= accept;
			raw_valid <= calc;
			if (accept)
				busy <= 1'b1;
			else if (norm_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge in_clk) begin
		if (accept) begin
			a_q <= a;
			b_q <= b;
			op_q <= op;
		end
		if (calc) begin
			raw_sign <= sign_d;
			raw_exp <= exp_d;
			raw_mant <= mant_d;
		end
	end

	assign a_sign = a_q[`FLOAT_BITS-1];
	assign b_sign = b_q[`FLOAT_BITS-1];
	assign a_exp = a_q[`FLOAT_BITS-2 -: `FLOAT_EXP_BITS];
	assign b_exp = b_q[`FLOAT_BITS-2 -: `FLOAT_EXP_BITS];
	assign a_mant = {1'b1, a_q[`FLOAT_MANT_BITS-1:0]};
	assign b_mant = {1'b1, b_q[`FLOAT_MANT_BITS-1:0]};

	// subtract is an add of the negated b
	assign b_eff_sign = b_sign ^ (op_q == OP_SUB);

	assign a_big = (a_exp >= b_exp);
	assign big_sign = a_big ? a_sign : b_eff_sign;
	assign small_sign = a_big ? b_eff_sign : a_sign;
	assign big_exp = a_big ? a_exp : b_exp;
	assign big_mant = a_big ? a_mant : b_mant;
	assign small_mant = a_big ? b_mant : a_mant;
	assign exp_diff = a_big ? (a_exp - b_exp) : (b_exp - a_exp);
	assign small_al = small_mant >> exp_diff;

	assign prod = a_mant * b_mant;
	assign quot = (wide_mant_t'(a_mant) << `FLOAT_MANT_BITS) / wide_mant_t'(b_mant);

	always_comb begin
		sign_d = a_sign ^ b_sign;
		exp_d = a_exp;
		mant_d = '0;

		case (op_q)
			OP_MUL: begin
				exp_d = a_exp + b_exp - BIAS;
				mant_d = wide_mant_t'(prod >> `FLOAT_MANT_BITS);
			end
			OP_DIV: begin
				// quotient sits MANT_SHIFT places high, the shift-down steps undo it
				exp_d = a_exp - MANT_SHIFT - b_exp + BIAS;
				mant_d = quot << `FLOAT_MANT_BITS;
			end
			OP_ADD, OP_SUB: begin
				exp_d = big_exp;
				if (big_sign == small_sign) begin
					mant_d = wide_mant_t'(big_mant) + wide_mant_t'(small_al);
					sign_d = big_sign;
				end else if (big_mant >= small_al) begin
					mant_d = wide_mant_t'(big_mant - small_al);
					sign_d = big_sign;
				end else begin
					// only with equal exponents
					mant_d = wide_mant_t'(small_al - big_mant);
					sign_d = small_sign;
				end
			end
		endcase
	end

endmodule

// ==== logic/float_norm.sv ====
// float result normaliser
`include "float_cfg.svh"

module float_norm (
	input  logic                  in_clk,
	input  logic                  in_rst,
	input  logic                  raw_valid,
	input  logic                  raw_sign,
	input  float_pkg::exp_t       raw_exp,
	input  float_pkg::wide_mant_t raw_mant,
	output float_pkg::float_t     result,
	output logic                  done
);
	import float_pkg::*;

	norm_state_t state;

	// working value
	logic       work_sign;
	exp_t       work_exp;
	wide_mant_t work_mant;

	logic over;      // bits set above the hidden bit
	logic under;     // hidden bit clear with stored bits left
	logic shift_dn;
	logic shift_up;
	logic finish;

	assign over = |work_mant[2*`FLOAT_MANT_BITS:`FLOAT_MANT_BITS+1];
	assign under = (|work_mant[`FLOAT_MANT_BITS-1:0]) && !work_mant[`FLOAT_MANT_BITS];

	// shift down first, only then check for a missing hidden bit
	assign shift_dn = (state == SHIFT_DOWN) && over;
	assign shift_up = ((state == SHIFT_DOWN) && !over && under) ||
		((state == SHIFT_UP) && under);
	assign finish = (state != IDLE) && !shift_dn && !shift_up;

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= IDLE;
			done <= 1'b0;
			result <= '0;
		end else begin
			done <= finish;
			if (finish)
				result <= {work_sign, work_exp, work_mant[`FLOAT_MANT_BITS-1:0]};

			case (state)
				IDLE:
					if (raw_valid)
						state <= SHIFT_DOWN;
				SHIFT_DOWN:
					if (finish)
						state <= IDLE;
					else if (shift_up)
						state <= SHIFT_UP;
				SHIFT_UP:
					if (finish)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge in_clk) begin
		if ((state == IDLE) && raw_valid) begin
			work_sign <= raw_sign;
			work_exp <= raw_exp;
			work_mant <= raw_mant;
		end else if (shift_dn) begin
			work_mant <= work_mant >> 1;
			work_exp <= work_exp + 1'b1;
		end else if (shift_up) begin
			work_mant <= work_mant << 1;
			work_exp <= work_exp - 1'b1;
		end
	end

endmodule

// ==== logic/float_unit.sv ====
// float unit top level
module float_unit (
	input  logic              in_clk,
	input  logic              in_rst,
	input  logic              start,
	input  float_pkg::float_t a,
	input  float_pkg::float_t b,
	input  float_pkg::op_t    op,
	output float_pkg::float_t result,
	output logic              done,
	output logic              ready
);
	import float_pkg::*;

	// raw step result into the normaliser
	logic       raw_valid;
	logic       raw_sign;
	exp_t       raw_exp;
	wide_mant_t raw_mant;

	float_arith arith_i (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.start     (start),
		.a         (a),
		.b         (b),
		.op        (op),
		.norm_done (done),       // frees the arithmetic step
		.ready     (ready),
		.raw_valid (raw_valid),
		.raw_sign  (raw_sign),
		.raw_exp   (raw_exp),
		.raw_mant  (raw_mant)
	);

	// no ready of its own, busy in float_arith keeps it from overlapping
	float_norm norm_i (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.raw_valid (raw_valid),
		.raw_sign  (raw_sign),
		.raw_exp   (raw_exp),
		.raw_mant  (raw_mant),
		.result    (result),
		.done      (done)
	);

endmodule

// ==== verification/float_unit_assert.sv ====
// float unit checker
`include "float_cfg.svh"

module float_unit_assert (
	input logic              in_clk,
	input logic              in_rst,
	input logic              start,
	input float_pkg::float_t a,
	input float_pkg::float_t b,
	input float_pkg::op_t    op,
	input float_pkg::float_t result,
	input logic              done,
	input logic              ready
);
	timeunit 1ns;
	timeprecision 100ps;

	import float_pkg::*;

	logic        accept;
	logic        pending;     // operation in flight
	logic        done_seen;
	float_t      expected_q;
	float_t      result_q;    // result one cycle back
	int unsigned fail_count = 0;

	// single word widened to double precision
	function automatic real to_real(input float_t f);
		logic [63:0] d;
		logic [10:0] e;
		e = 11'(f[`FLOAT_BITS-2 -: `FLOAT_EXP_BITS]) + 11'(1023 - `FLOAT_EXP_BIAS);
		d = {f[`FLOAT_BITS-1], e, f[`FLOAT_MANT_BITS-1:0], {(52 - `FLOAT_MANT_BITS){1'b0}}};
		return $bitstoreal(d);
	endfunction

	// exact values only, low bits dropped
	function automatic float_t to_float(input real r);
		logic [63:0] d;
		logic [10:0] e;
		d = $realtobits(r);
		e = d[62:52] - 11'(1023 - `FLOAT_EXP_BIAS);
		return {d[63], e[`FLOAT_EXP_BITS-1:0], d[51 -: `FLOAT_MANT_BITS]};
	endfunction

	function automatic float_t model_result(input float_t x, input float_t y, input op_t o);
		real xr;
		real yr;
		real r;
		xr = to_real(x);
		yr = to_real(y);
		case (o)
			OP_MUL: r = xr * yr;
			OP_DIV: r = xr / yr;
			OP_ADD: r = xr + yr;
			default: r = xr - yr;
		endcase
		return to_float(r);
	endfunction

	assign accept = start && ready;

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			pending <= 1'b0;
			done_seen <= 1'b0;
			expected_q <= '0;
			result_q <= '0;
		end else begin
			result_q <= result;
			if (accept) begin
				pending <= 1'b1;
				expected_q <= model_result(a, b, op);
			end else if (done) begin
				pending <= 1'b0;
			end
			if (done)
				done_seen <= 1'b1;
		end
	end

	ready_level: assert property (@(posedge in_clk) disable iff (in_rst)
		ready != pending)
		else begin
			$error("ready does not match the operation in flight");
			fail_count++;
		end

	done_owned: assert property (@(posedge in_clk) disable iff (in_rst)
		done |-> pending)
		else begin
			$error("done pulsed with no operation in flight");
			fail_count++;
		end

	done_single: assert property (@(posedge in_clk) disable iff (in_rst)
		done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			fail_count++;
		end

	ready_after_done: assert property (@(posedge in_clk) disable iff (in_rst)
		done |=> ready)
		else begin
			$error("ready did not rise on the cycle after done");
			fail_count++;
		end

	result_value: assert property (@(posedge in_clk) disable iff (in_rst)
		done |-> (result == expected_q))
		else begin
			$error("error: time %0t result expected %h actual %h", $time, expected_q, result);
			fail_count++;
		end

	// holds between done pulses
	result_hold: assert property (@(posedge in_clk) disable iff (in_rst)
		!done |-> (result == result_q))
		else begin
			$error("error: time %0t result expected %h actual %h", $time, result_q, result);
			fail_count++;
		end

	result_reset: assert property (@(posedge in_clk) disable iff (in_rst)
		(!done_seen && !done) |-> (result == '0))
		else begin
			$error("error: time %0t result expected %h actual %h", $time, 32'h0, result);
			fail_count++;
		end

endmodule

// ==== verification/float_unit_tb.sv ====
// float unit testbench
`include "float_cfg.svh"

module float_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import float_pkg::*;

	localparam int READY_LIMIT = 50;
	localparam int DONE_LIMIT = 200;

	logic        in_clk = 1'b0;
	logic        in_rst;
	logic        start;
	float_t      a;
	float_t      b;
	op_t         op;
	float_t      result;
	logic        done;
	logic        ready;

	float_unit dut_i (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.start  (start),
		.a      (a),
		.b      (b),
		.op     (op),
		.result (result),
		.done   (done),
		.ready  (ready)
	);

	bind float_unit float_unit_assert check_i (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.start  (start),
		.a      (a),
		.b      (b),
		.op     (op),
		.result (result),
		.done   (done),
		.ready  (ready)
	);

	always #4 in_clk = ~in_clk;

	// a failed assertion ends the run
	always @(negedge in_clk) begin
		if (dut_i.check_i.fail_count != 0) begin
			$display("tests failed");
			$fatal(1, "a checker assertion failed");
		end
	end

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped on a timeout");
	endtask

	// integer to float word exact up to 24 significant bits
	function automatic float_t int_to_float(input int value);
		logic        neg;
		int unsigned mag;
		int unsigned shifted;
		int          msb;
		neg = (value < 0);
		mag = unsigned'(neg ? -value : value);
		msb = 0;
		for (int i = 0; i < 32; i++)
			if (mag[i])
				msb = i;
		shifted = mag << (`FLOAT_MANT_BITS - msb);  // leading one lands on the hidden bit
		return {neg, exp_t'(`FLOAT_EXP_BIAS + msb), shifted[`FLOAT_MANT_BITS-1:0]};
	endfunction

	function automatic float_t power_of_two(input int k, input logic neg);
		return {neg, exp_t'(`FLOAT_EXP_BIAS + k), {`FLOAT_MANT_BITS{1'b0}}};
	endfunction

	// magnitude 1 to 1023 with either sign
	function automatic int random_int();
		int mag;
		mag = int'($urandom_range(1023, 1));
		return ($urandom_range(1, 0) == 1) ? -mag : mag;
	endfunction

	// one operation from ready to done
	task automatic run_op(input float_t x, input float_t y, input op_t o);
		int cycles;
		cycles = 0;
		@(posedge in_clk);
		while (!ready) begin
			cycles++;
			if (cycles > READY_LIMIT)
				stop_on_timeout("ready stayed low");
			@(posedge in_clk);
		end
		start <= 1'b1;
		a <= x;
		b <= y;
		op <= o;
		@(posedge in_clk);
		start <= 1'b0;
		cycles = 0;
		do begin
			@(posedge in_clk);
			cycles++;
			if (cycles > DONE_LIMIT)
				stop_on_timeout("done never came");
		end while (!done);
	endtask

	task automatic run_int_op(input int x, input int y, input op_t o);
		run_op(int_to_float(x), int_to_float(y), o);
	endtask

	task automatic idle_gap();
		repeat ($urandom_range(3, 0)) @(posedge in_clk);
	endtask

	initial begin
		int   x;
		int   y;
		int   q;
		int   d;
		int   k;
		op_t  o;
		logic neg;

		void'($urandom(70));
		in_rst = 1'b1;
		start = 1'b0;
		a = '0;
		b = '0;
		op = OP_MUL;

		repeat (5) @(posedge in_clk);
		in_rst <= 1'b0;
		repeat (3) @(posedge in_clk);  // idle after reset

		// 1.5 * 1.5 in the first multiply needs a shift down
		run_int_op(3, 3, OP_MUL);
		run_int_op(-1023, 1023, OP_MUL);
		run_int_op(1, -1, OP_MUL);
		run_int_op(768, -5, OP_MUL);
		run_int_op(-12, -85, OP_MUL);

		// divides with smaller and larger dividends
		run_op(int_to_float(1000), power_of_two(3, 1'b0), OP_DIV);
		run_op(int_to_float(3), power_of_two(10, 1'b0), OP_DIV);
		run_op(int_to_float(-7), power_of_two(-2, 1'b1), OP_DIV);
		run_int_op(961, 31, OP_DIV);
		run_int_op(-6, 3, OP_DIV);
		run_int_op(9, 3, OP_DIV);

		// add and subtract
		run_int_op(1023, 1022, OP_SUB);   // deep cancellation
		run_int_op(-1000, 999, OP_ADD);
		run_int_op(512, 511, OP_SUB);
		run_int_op(3, 1000, OP_ADD);
		run_int_op(1000, 3, OP_ADD);
		run_int_op(-5, 700, OP_SUB);
		run_int_op(700, -5, OP_SUB);
		run_int_op(1, -1023, OP_ADD);
		run_int_op(6, 6, OP_ADD);
		run_int_op(5, -7, OP_ADD);        // equal exponents and b larger

		for (int i = 0; i < 24; i++) begin
			run_int_op(random_int(), random_int(), OP_MUL);
			idle_gap();
		end

		for (int i = 0; i < 24; i++) begin
			x = random_int();
			y = random_int();
			o = ($urandom_range(1, 0) == 1) ? OP_SUB : OP_ADD;
			// keep the exact result away from zero
			if ((o == OP_ADD && x == -y) || (o == OP_SUB && x == y))
				y = -y;
			run_int_op(x, y, o);
			idle_gap();
		end

		for (int i = 0; i < 12; i++) begin
			k = int'($urandom_range(14, 0)) - 4;
			neg = 1'($urandom_range(1, 0));
			run_op(int_to_float(random_int()), power_of_two(k, neg), OP_DIV);
			idle_gap();
		end

		// integer quotients
		for (int i = 0; i < 12; i++) begin
			q = int'($urandom_range(31, 1));
			d = int'($urandom_range(31, 1));
			if ($urandom_range(1, 0) == 1)
				q = -q;
			if ($urandom_range(1, 0) == 1)
				d = -d;
			run_int_op(q * d, d, OP_DIV);
			idle_gap();
		end

		repeat (2) @(posedge in_clk);
		if (dut_i.check_i.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "checker reported failures");
		end
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/float_pkg.sv
logic/float_arith.sv
logic/float_norm.sv
logic/float_unit.sv
verification/float_unit_assert.sv
verification/float_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = float_unit_tb
FILE_LIST = files.f
RUN_FLAGS = +verilator+error+limit+10
PASS_MSG  = all tests passed
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
